// ==== include/cache_config.svh ====
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Address and word widths
`define CACHE_ADDR_W    32
`define CACHE_DATA_W    32

// Set associativity
`define CACHE_WAYS      4
`define CACHE_WAY_W     2

// Sets, one block of one word each way
`define CACHE_SETS      16
`define CACHE_INDEX_W   4

// Byte offset inside the word, zero on the bus
`define CACHE_OFFSET_W  2

// Tag takes the remaining address bits
`define CACHE_TAG_W     26

`endif

// ==== src/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    // Line coherence state
    typedef enum logic [1:0] {
        MesiInvalid   = 2'b00,
        MesiShared    = 2'b01,
        MesiExclusive = 2'b10,
        MesiModified  = 2'b11
    } mesiState;

    // Controller sequencing states
    typedef enum logic [2:0] {
        StIdle,
        StLookup,
        StWriteBack,
        StFill,
        StUpgrade,
        StUpdate,
        StDone
    } ctrlState;

    // Bus operation currently requested by the controller
    typedef enum logic [2:0] {
        OpNone,
        OpRead,
        OpReadEx,
        OpInvalidate,
        OpWriteBack
    } busOp;

endpackage

`default_nettype wire

// ==== src/cache_array_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

interface cache_array_if
    import cache_pkg::*;
();

    // Lookup address from the controller
    logic [`CACHE_INDEX_W-1:0] index;
    logic [`CACHE_TAG_W-1:0]   tag;
    // Way that is read and written
    logic [`CACHE_WAY_W-1:0]   accessWay;

    // Tag and state update
    logic                      tagWrite;
    logic [`CACHE_TAG_W-1:0]   newTag;
    mesiState                  newState;

    // Word update
    logic                      dataWrite;
    logic [`CACHE_DATA_W-1:0]  writeData;

    // Lookup results
    logic                      hit;
    logic [`CACHE_WAY_W-1:0]   hitWay;
    mesiState                  wayState;
    logic [`CACHE_TAG_W-1:0]   wayTag;
    logic                      freeFound;
    logic [`CACHE_WAY_W-1:0]   freeWay;

    // Stored word at index and access way
    logic [`CACHE_DATA_W-1:0]  readData;

    modport ctrl (
        output index, tag, accessWay, tagWrite, newTag, newState, dataWrite, writeData,
        input  hit, hitWay, wayState, wayTag, freeFound, freeWay, readData
    );

    modport tags (
        input  index, tag, accessWay, tagWrite, newTag, newState,
        output hit, hitWay, wayState, wayTag, freeFound, freeWay
    );

    modport data (
        input  index, accessWay, dataWrite, writeData,
        output readData
    );

endinterface

`default_nettype wire

// ==== src/cache_control_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module cache_control_fsm
    import cache_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cpuRead,
    input  logic                      cpuWrite,
    input  logic [`CACHE_ADDR_W-1:0]  cpuAddr,
    input  logic [`CACHE_DATA_W-1:0]  cpuWriteData,
    output logic [`CACHE_DATA_W-1:0]  cpuReadData,
    output logic                      cpuDone,
    output logic                      busReq,
    input  logic                      busGnt,
    output logic [`CACHE_ADDR_W-1:0]  busAddr,
    output logic [`CACHE_DATA_W-1:0]  busWriteData,
    output logic                      busRead,
    output logic                      busReadEx,
    output logic                      busInvalidate,
    output logic                      memWrite,
    input  logic [`CACHE_DATA_W-1:0]  busReadData,
    input  logic                      dataInBus,
    input  logic                      sharedIn,
    input  logic                      memWriteDone,
    input  logic                      allInvalidationDone,
    input  logic [`CACHE_WAY_W-1:0]   victimWay,
    output logic                      fillNoFree,
    cache_array_if.ctrl               arrays
);

    ctrlState                  state;
    ctrlState                  nextState;
    busOp                      op;
    logic [`CACHE_TAG_W-1:0]   reqTag;
    logic [`CACHE_INDEX_W-1:0] reqIndex;
    logic [`CACHE_WAY_W-1:0]   missWay;
    logic [`CACHE_WAY_W-1:0]   lookupWay;
    logic [`CACHE_WAY_W-1:0]   wayReg;
    logic                      noFreeReg;

    // Address split, byte offset ignored
    assign reqTag   = cpuAddr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign reqIndex = cpuAddr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    assign arrays.index = reqIndex;
    assign arrays.tag   = reqTag;

    // Free way first, round robin victim otherwise
    assign missWay   = arrays.freeFound ? arrays.freeWay : victimWay;
    assign lookupWay = arrays.hit ? arrays.hitWay : missWay;
    // Way is chosen live in Lookup and held after that
    assign arrays.accessWay = (state == StLookup) ? lookupWay : wayReg;

    // Bus operation follows the state
    always_comb
    begin
        case (state)
            StWriteBack: op = OpWriteBack;
            StFill:      op = cpuWrite ? OpReadEx : OpRead;
            StUpgrade:   op = OpInvalidate;
            default:     op = OpNone;
        endcase
    end

    // Request held for the whole bus phase, strobes only under grant
    assign busReq        = (op != OpNone);
    assign busRead       = busGnt && (op == OpRead);
    assign busReadEx     = busGnt && (op == OpReadEx);
    assign busInvalidate = busGnt && (op == OpInvalidate);
    assign memWrite      = busGnt && (op == OpWriteBack);
    // Victim address on write-back, block address otherwise
    assign busAddr = (op == OpWriteBack) ?
                     {arrays.wayTag, reqIndex, {`CACHE_OFFSET_W{1'b0}}} :
                     {reqTag, reqIndex, {`CACHE_OFFSET_W{1'b0}}};
    assign busWriteData = arrays.readData;

    assign cpuDone     = (state == StDone);
    assign cpuReadData = arrays.readData;

    always_comb
    begin
        nextState        = state;
        arrays.tagWrite  = 1'b0;
        arrays.newTag    = reqTag;
        arrays.newState  = MesiModified;
        arrays.dataWrite = 1'b0;
        arrays.writeData = cpuWriteData;
        fillNoFree       = 1'b0;
        case (state)
            StIdle:
            begin
                if (cpuRead || cpuWrite)
                    nextState = StLookup;
            end
            StLookup:
            begin
                if (arrays.hit)
                begin
                    if (!cpuWrite)
                        nextState = StDone;
                    // Shared copy needs the others invalidated first
                    else if (arrays.wayState == MesiShared)
                        nextState = StUpgrade;
                    else
                    begin
                        // Exclusive or Modified, write in place
                        arrays.tagWrite  = 1'b1;
                        arrays.dataWrite = 1'b1;
                        nextState        = StDone;
                    end
                end
                else if (arrays.wayState == MesiModified)
                    nextState = StWriteBack;
                else
                    nextState = StFill;
            end
            StWriteBack:
            begin
                if (busGnt && memWriteDone)
                    nextState = StFill;
            end
            StFill:
            begin
                if (busGnt && dataInBus)
                begin
                    // Capture the bus word with the new tag and state
                    arrays.tagWrite  = 1'b1;
                    arrays.dataWrite = 1'b1;
                    arrays.writeData = busReadData;
                    if (!cpuWrite)
                        arrays.newState = sharedIn ? MesiShared : MesiExclusive;
                    fillNoFree = noFreeReg;
                    nextState  = StUpdate;
                end
            end
            StUpgrade:
            begin
                if (busGnt && allInvalidationDone)
                    nextState = StUpdate;
            end
            StUpdate:
            begin
                // Processor word goes over the filled or upgraded line
                if (cpuWrite)
                begin
                    arrays.tagWrite  = 1'b1;
                    arrays.dataWrite = 1'b1;
                end
                nextState = StDone;
            end
            default:
                nextState = StIdle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= StIdle;
        else
            state <= nextState;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            noFreeReg <= 1'b0;
        else if (state == StLookup)
            noFreeReg <= !arrays.freeFound;
    end

    // Access way kept for the rest of the request
    always_ff @(posedge clk)
    begin
        if (state == StLookup)
            wayReg <= lookupWay;
    end

endmodule

`default_nettype wire

// ==== src/victim_pointer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module victim_pointer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`CACHE_INDEX_W-1:0] index,
    input  logic                      advance,
    output logic [`CACHE_WAY_W-1:0]   victimWay
);

    // One counter per set
    logic [`CACHE_WAY_W-1:0] pointer [`CACHE_SETS];

    assign victimWay = pointer[index];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int s = 0; s < `CACHE_SETS; s++)
                pointer[s] <= '0;
        end
        // Steps after a replacement, wraps past the last way
        else if (advance)
            pointer[index] <= pointer[index] + 1'b1;
    end

endmodule

`default_nettype wire

// ==== src/tag_state_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module tag_state_array
    import cache_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     snoopValid,
    input  logic                     snoopInvalidate,
    input  logic [`CACHE_ADDR_W-1:0] snoopAddr,
    output logic                     invalidationDone,
    cache_array_if.tags              arrays
);

    logic [`CACHE_TAG_W-1:0]   lineTag   [`CACHE_SETS][`CACHE_WAYS];
    mesiState                  lineState [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_TAG_W-1:0]   snoopTag;
    logic [`CACHE_INDEX_W-1:0] snoopIndex;
    logic                      snoopHit;
    logic [`CACHE_WAY_W-1:0]   snoopWay;

    assign snoopTag   = snoopAddr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign snoopIndex = snoopAddr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];

    // Access way view for the controller
    assign arrays.wayState = lineState[arrays.index][arrays.accessWay];
    assign arrays.wayTag   = lineTag[arrays.index][arrays.accessWay];

    // Processor compare over all ways
    // Descending scan so the lowest way wins
    always_comb
    begin
        arrays.hit       = 1'b0;
        arrays.hitWay    = '0;
        arrays.freeFound = 1'b0;
        arrays.freeWay   = '0;
        for (int w = `CACHE_WAYS - 1; w >= 0; w--)
        begin
            if (lineState[arrays.index][w] == MesiInvalid)
            begin
                arrays.freeFound = 1'b1;
                arrays.freeWay   = `CACHE_WAY_W'(w);
            end
            else if (lineTag[arrays.index][w] == arrays.tag)
            begin
                arrays.hit    = 1'b1;
                arrays.hitWay = `CACHE_WAY_W'(w);
            end
        end
    end

    // Snoop compare, only for an invalidate
    always_comb
    begin
        snoopHit = 1'b0;
        snoopWay = '0;
        for (int w = `CACHE_WAYS - 1; w >= 0; w--)
        begin
            if (lineState[snoopIndex][w] != MesiInvalid &&
                lineTag[snoopIndex][w] == snoopTag)
            begin
                snoopHit = snoopValid && snoopInvalidate;
                snoopWay = `CACHE_WAY_W'(w);
            end
        end
    end

    // Line states, all Invalid out of reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int s = 0; s < `CACHE_SETS; s++)
                for (int w = 0; w < `CACHE_WAYS; w++)
                    lineState[s][w] <= MesiInvalid;
        end
        else
        begin
            if (arrays.tagWrite)
                lineState[arrays.index][arrays.accessWay] <= arrays.newState;
            // Snoop never overlaps a processor request
            if (snoopHit)
                lineState[snoopIndex][snoopWay] <= MesiInvalid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (arrays.tagWrite)
            lineTag[arrays.index][arrays.accessWay] <= arrays.newTag;
    end

    // Confirmation one cycle after the matching snoop
    always_ff @(posedge clk)
    begin
        if (reset)
            invalidationDone <= 1'b0;
        else
            invalidationDone <= snoopHit;
    end

endmodule

`default_nettype wire

// ==== src/data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module data_array (
    input  logic        clk,
    cache_array_if.data arrays
);

    // One word per line
    logic [`CACHE_DATA_W-1:0] word [`CACHE_SETS][`CACHE_WAYS];

    // Asynchronous read at the access way
    assign arrays.readData = word[arrays.index][arrays.accessWay];

    always_ff @(posedge clk)
    begin
        if (arrays.dataWrite)
            word[arrays.index][arrays.accessWay] <= arrays.writeData;
    end

endmodule

`default_nettype wire

// ==== src/cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module cache_top (
    input  logic                     clk,
    input  logic                     reset,
    // Processor side
    input  logic                     cpuRead,
    input  logic                     cpuWrite,
    input  logic [`CACHE_ADDR_W-1:0] cpuAddr,
    input  logic [`CACHE_DATA_W-1:0] cpuWriteData,
    output logic [`CACHE_DATA_W-1:0] cpuReadData,
    output logic                     cpuDone,
    // Common bus
    output logic                     busReq,
    input  logic                     busGnt,
    output logic [`CACHE_ADDR_W-1:0] busAddr,
    output logic [`CACHE_DATA_W-1:0] busWriteData,
    output logic                     busRead,
    output logic                     busReadEx,
    output logic                     busInvalidate,
    output logic                     memWrite,
    input  logic [`CACHE_DATA_W-1:0] busReadData,
    input  logic                     dataInBus,
    input  logic                     sharedIn,
    input  logic                     memWriteDone,
    input  logic                     allInvalidationDone,
    // Snoop side
    input  logic                     snoopValid,
    input  logic                     snoopInvalidate,
    input  logic [`CACHE_ADDR_W-1:0] snoopAddr,
    output logic                     invalidationDone
);

    logic [`CACHE_WAY_W-1:0] victimWay;
    logic                    fillNoFree;

    cache_array_if arrays ();

    cache_control_fsm i_ctrl (
        .clk                 (clk),
        .reset               (reset),
        .cpuRead             (cpuRead),
        .cpuWrite            (cpuWrite),
        .cpuAddr             (cpuAddr),
        .cpuWriteData        (cpuWriteData),
        .cpuReadData         (cpuReadData),
        .cpuDone             (cpuDone),
        .busReq              (busReq),
        .busGnt              (busGnt),
        .busAddr             (busAddr),
        .busWriteData        (busWriteData),
        .busRead             (busRead),
        .busReadEx           (busReadEx),
        .busInvalidate       (busInvalidate),
        .memWrite            (memWrite),
        .busReadData         (busReadData),
        .dataInBus           (dataInBus),
        .sharedIn            (sharedIn),
        .memWriteDone        (memWriteDone),
        .allInvalidationDone (allInvalidationDone),
        .victimWay           (victimWay),
        .fillNoFree          (fillNoFree),
        .arrays              (arrays.ctrl)
    );

    // Replacement counter follows the lookup index
    victim_pointer i_victim (
        .clk       (clk),
        .reset     (reset),
        .index     (arrays.index),
        .advance   (fillNoFree),
        .victimWay (victimWay)
    );

    tag_state_array i_tags (
        .clk              (clk),
        .reset            (reset),
        .snoopValid       (snoopValid),
        .snoopInvalidate  (snoopInvalidate),
        .snoopAddr        (snoopAddr),
        .invalidationDone (invalidationDone),
        .arrays           (arrays.tags)
    );

    data_array i_data (
        .clk    (clk),
        .arrays (arrays.data)
    );

endmodule

`default_nettype wire

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int HalfPeriod = 10
) (
    output logic clk
);

    // 20 ns period
    initial
    begin
        clk = 1'b0;
        forever
            #HalfPeriod clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== bench/bus_memory_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_memory_model (
    input  logic        clk,
    input  logic        reset,
    input  logic        busReq,
    input  logic [31:0] busAddr,
    input  logic [31:0] busWriteData,
    input  logic        busRead,
    input  logic        busReadEx,
    input  logic        busInvalidate,
    input  logic        memWrite,
    output logic        busGnt,
    output logic [31:0] busReadData,
    output logic        dataInBus,
    output logic        sharedIn,
    output logic        memWriteDone,
    output logic        allInvalidationDone
);

    // Only written-back words are stored
    logic [31:0] mem [logic [31:0]];
    int unsigned delay;
    logic        seeded;

    function automatic logic [31:0] memWord(input logic [31:0] addr);
        if (mem.exists(addr))
            return mem[addr];
        return addr ^ 32'hA5A5_0000;
    endfunction

    initial
    begin
        seeded              = 1'b0;
        busGnt              = 1'b0;
        busReadData         = '0;
        dataInBus           = 1'b0;
        sharedIn            = 1'b0;
        memWriteDone        = 1'b0;
        allInvalidationDone = 1'b0;
        delay               = 0;
    end

    // Outputs change 1 ns after the edge and answers last one cycle
    always @(posedge clk)
    begin
        #1;
        // Fixed seed on first use
        if (!seeded)
        begin
            void'($urandom(30667));
            seeded = 1'b1;
        end
        dataInBus           = 1'b0;
        memWriteDone        = 1'b0;
        allInvalidationDone = 1'b0;
        sharedIn            = 1'b0;
        if (reset || !busReq)
        begin
            busGnt = 1'b0;
            delay  = $urandom % 4;
        end
        else if (!busGnt)
        begin
            // Random 0 to 3 cycle grant delay
            if (delay == 0)
                busGnt = 1'b1;
            else
                delay--;
        end
        else if (busRead || busReadEx)
        begin
            busReadData = memWord(busAddr);
            sharedIn    = busAddr[10];
            dataInBus   = 1'b1;
        end
        else if (memWrite)
        begin
            mem[busAddr] = busWriteData;
            memWriteDone = 1'b1;
        end
        else if (busInvalidate)
            allInvalidationDone = 1'b1;
    end

endmodule

`default_nettype wire

// ==== bench/cache_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_asserts (
    input logic clk,
    input logic reset,
    input logic busReq,
    input logic busGnt,
    input logic busRead,
    input logic busReadEx,
    input logic busInvalidate,
    input logic memWrite,
    input logic dataInBus,
    input logic memWriteDone,
    input logic allInvalidationDone,
    input logic cpuDone,
    input logic invalidationDone,
    input logic snoopValid,
    input logic snoopInvalidate
);

    // Read by the testbench at the end of the run
    int violations = 0;

    // Quiet outputs right out of reset
    idleAfterReset: assert property (@(posedge clk) $fell(reset) |->
        !busReq && !busRead && !busReadEx && !busInvalidate && !memWrite &&
        !cpuDone && !invalidationDone)
    else
    begin
        violations++;
        $error("outputs active right after reset");
    end

    // Strobes only under grant
    strobeNeedsGrant: assert property (@(posedge clk) disable iff (reset)
        (busRead || busReadEx || busInvalidate || memWrite) |-> busGnt)
    else
    begin
        violations++;
        $error("bus strobe without grant");
    end

    // Request released only after an answer
    reqHeldToAnswer: assert property (@(posedge clk) disable iff (reset)
        $fell(busReq) |-> $past(dataInBus || memWriteDone || allInvalidationDone))
    else
    begin
        violations++;
        $error("busReq dropped before the answer");
    end

    // Done is a single-cycle pulse
    donePulse: assert property (@(posedge clk) disable iff (reset) cpuDone |=> !cpuDone)
    else
    begin
        violations++;
        $error("cpuDone longer than one cycle");
    end

    snoopConfirm: assert property (@(posedge clk) disable iff (reset)
        invalidationDone |-> $past(snoopValid && snoopInvalidate))
    else
    begin
        violations++;
        $error("invalidationDone without a snoop");
    end

endmodule

bind cache_top cache_asserts i_asserts (.*);

`default_nettype wire

// ==== bench/cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

    localparam int MaxCycles = 3000;
    localparam logic [1:0] RefI = 2'd0;
    localparam logic [1:0] RefS = 2'd1;
    localparam logic [1:0] RefE = 2'd2;
    localparam logic [1:0] RefM = 2'd3;

    logic clk, reset;
    logic cpuRead, cpuWrite, cpuDone;
    logic [31:0] cpuAddr, cpuWriteData, cpuReadData;
    logic busReq, busGnt, busRead, busReadEx, busInvalidate, memWrite;
    logic [31:0] busAddr, busWriteData, busReadData;
    logic dataInBus, sharedIn, memWriteDone, allInvalidationDone;
    logic snoopValid, snoopInvalidate, invalidationDone;
    logic [31:0] snoopAddr;

    // Reference model of words and line states
    logic [31:0] refWord [logic [31:0]];
    logic [1:0]  refState [logic [31:0]];
    logic [31:0] expData;
    logic wasShared;
    int errors = 0;
    int testErrors = 0;
    int tests = 0;
    int cycles = 0;
    int lat;
    logic sawReq, sawRead, sawReadEx, sawInv, sawWb, readAfterWb, sawInvDone;
    logic [31:0] readAddr, wbAddr, wbData;

    clock_gen i_clk (.clk(clk));

    bus_memory_model i_bus (.*);

    cache_top i_dut (.*);

    // Read data checked at every read completion
    readDataCheck: assert property (@(posedge clk) disable iff (reset)
        (cpuDone && cpuRead) |-> cpuReadData == expData)
    else
    begin
        errors++;
        $display("ERR %0t cpuReadData got %h expected %h",
                 $time, $sampled(cpuReadData), expData);
    end

    function automatic logic [31:0] expectWord(input logic [31:0] addr);
        if (refWord.exists(addr))
            return refWord[addr];
        return addr ^ 32'hA5A5_0000;
    endfunction

    task automatic require(input logic cond, input string what);
        assert (cond)
        else
        begin
            errors++;
            $display("%0t: %s", $time, what);
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Bus activity sampled at the falling edge where outputs are settled
    always @(negedge clk)
    begin
        if (busReq)
            sawReq = 1'b1;
        if (busReadEx)
            sawReadEx = 1'b1;
        if (busInvalidate)
            sawInv = 1'b1;
        if (invalidationDone)
            sawInvDone = 1'b1;
        if (busRead)
        begin
            sawRead  = 1'b1;
            readAddr = busAddr;
            if (sawWb)
                readAfterWb = 1'b1;
        end
        if (memWrite)
        begin
            sawWb  = 1'b1;
            wbAddr = busAddr;
            wbData = busWriteData;
        end
    end

    task automatic clearFlags();
        {sawReq, sawRead, sawReadEx, sawInv, sawWb, readAfterWb, sawInvDone} = '0;
    endtask

    // One processor request held until cpuDone
    task automatic access(input logic wr, input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        clearFlags();
        expData      = expectWord(addr);
        cpuRead      = !wr;
        cpuWrite     = wr;
        cpuAddr      = addr;
        cpuWriteData = data;
        lat          = 0;
        do
        begin
            @(negedge clk);
            lat++;
        end
        while (!cpuDone);
        @(posedge clk);
        #1;
        cpuRead  = 1'b0;
        cpuWrite = 1'b0;
        if (wr)
        begin
            refWord[addr]  = data;
            refState[addr] = RefM;
        end
        else if (!refState.exists(addr) || refState[addr] == RefI)
            refState[addr] = addr[10] ? RefS : RefE;
    endtask

    task automatic snoop(input logic [31:0] addr);
        clearFlags();
        snoopValid      = 1'b1;
        snoopInvalidate = 1'b1;
        snoopAddr       = addr;
        @(posedge clk);
        #1;
        snoopValid      = 1'b0;
        snoopInvalidate = 1'b0;
        @(negedge clk);
        if (refState.exists(addr))
            refState[addr] = RefI;
    endtask

    task automatic endTest(input string name);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == testErrors) ? "ok" : "errors");
        testErrors = errors;
    endtask

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MaxCycles)
        begin
            $display("timeout: no completion after %0d cycles", MaxCycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial
    begin
        {cpuRead, cpuWrite, snoopValid, snoopInvalidate} = '0;
        cpuAddr = '0;
        cpuWriteData = '0;
        snoopAddr = '0;
        expData = '0;
        wasShared = 1'b0;
        clearFlags();
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (3) @(negedge clk);
        require(!busReq && !busRead && !busReadEx && !busInvalidate && !memWrite &&
                !cpuDone && !invalidationDone, "outputs active while idle after reset");
        endTest("reset");

        access(0, 32'h0000_100C, '0);
        require(sawRead, "read miss gave no busRead");
        checkValue("busAddr", readAddr, 32'h0000_100C);
        access(0, 32'h0000_100C, '0);
        checkValue("cpuDone latency", lat, 3);
        require(!sawReq, "read hit used the bus");
        endTest("read miss and hit");

        access(1, 32'h0000_100C, 32'h1111_2222);
        require(!sawReq, "write hit on Exclusive used the bus");
        access(0, 32'h0000_100C, '0);
        access(0, 32'h0000_0404, '0);
        wasShared = (refState[32'h0000_0404] == RefS);
        access(1, 32'h0000_0404, 32'h3333_4444);
        require(sawInv == wasShared, "busInvalidate did not follow the Shared state");
        access(1, 32'h0000_2008, 32'h5555_6666);
        require(sawReadEx, "write miss gave no busReadEx");
        endTest("writes");

        for (int t = 1; t <= 5; t++)
            access(0, (t << 12) | 32'h14, '0);
        access(0, 32'h0000_2014, '0);
        require(!sawReq, "second line lost after fifth fill");
        access(0, 32'h0000_1014, '0);
        require(sawRead, "way 0 line was not the one replaced");
        access(1, 32'h0000_101C, 32'hCAFE_0001);
        for (int t = 2; t <= 4; t++)
            access(0, (t << 12) | 32'h1C, '0);
        access(0, 32'h0000_501C, '0);
        require(sawWb, "Modified victim was not written back");
        checkValue("busAddr", wbAddr, 32'h0000_101C);
        checkValue("busWriteData", wbData, expectWord(32'h0000_101C));
        require(readAfterWb, "fill did not follow the write-back");
        access(0, 32'h0000_101C, '0);
        require(sawRead, "re-read of evicted line did not miss");
        endTest("eviction");

        access(0, 32'h0000_0418, '0);
        snoop(32'h0000_0418);
        require(invalidationDone, "no invalidationDone the cycle after a snoop hit");
        access(0, 32'h0000_0418, '0);
        require(sawRead, "snooped line still hit");
        snoop(32'h0000_7780);
        repeat (3) @(negedge clk);
        require(!sawInvDone, "snoop miss produced invalidationDone");
        endTest("snoop");

        repeat (2) @(negedge clk);
        // Protocol assertion failures over the whole run
        errors += i_dut.i_asserts.violations;
        endTest("bus discipline");

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
src/cache_pkg.sv
src/cache_array_if.sv
src/cache_control_fsm.sv
src/victim_pointer.sv
src/tag_state_array.sv
src/data_array.sv
src/cache_top.sv
bench/clock_gen.sv
bench/bus_memory_model.sv
bench/cache_asserts.sv
bench/cache_tb.sv

// ==== Makefile ====
# Verilator build and run for the MESI cache testbench
VERILATOR   ?= verilator
TOP         ?= cache_tb
BUILD_DIR   ?= obj_dir
FILELIST    ?= filelist.f
VFLAGS      ?= --binary --timing --assert
PASS_TEXT   ?= \*\*\* PASSED \*\*\*

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
